/* design/isa_pkg.sv */
package isa_pkg;

    // field widths of the MIPS32 instruction word
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    localparam reg_addr_t REG_ZERO    = 5'd0;
    localparam reg_addr_t REG_RA      = 5'd31;  // jal link register
    localparam word_t     LINK_OFFSET = 32'd8;  // return past the delay slot

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_JAL   = 6'h03,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // r-type layout; i-type reuses the low 16 bits as the immediate
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        shamt_t              shamt;
        logic [FUNCT_W-1:0]  funct;
    } instr_fields_t;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // funct is resolved into this in decode, execute only sees alu_op
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // bubble decodes to add of zeros
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11,
        ALU_LINK = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        REGDST_RT = 2'd0,
        REGDST_RD = 2'd1,
        REGDST_RA = 2'd2
    } regdst_e;

    // writeback source select
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic    alu_src;   // operand b from imm
        regdst_e regdst;
        logic    reg_write;
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_read;
        wb_sel_e mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        logic      illegal;
        word_t     pc;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
    } ex_bundle_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t dest;
        word_t     store_data;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   mem_to_reg;
    } ex_out_t;

    localparam ex_bundle_t EX_BUBBLE = '0;

endpackage

/* design/control_decoder.sv */
module control_decoder
    import isa_pkg::*, pipe_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl,
    output word_t imm,
    output logic  illegal
);

    instr_fields_t    fields;
    opcode_e          opcode;
    funct_e           funct;
    logic [IMM_W-1:0] imm16;
    logic             zero_ext;

    assign fields = instr_fields_t'(instr);
    assign opcode = opcode_e'(fields.opcode);
    assign funct  = funct_e'(fields.funct);
    assign imm16  = instr[IMM_W-1:0];

    // logical immediates zero-extend, the rest sign-extend
    assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign imm      = zero_ext ? word_t'(imm16)
                               : {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};

    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regdst    = REGDST_RD;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;  // no overflow trap
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_SLL:          ctrl.alu_op = ALU_SLL;
                    FN_SRL:          ctrl.alu_op = ALU_SRL;
                    FN_SRA:          ctrl.alu_op = ALU_SRA;
                    default:         illegal     = 1'b1;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI: ctrl.alu_op = ALU_SLT;
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_XORI: ctrl.alu_op = ALU_XOR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.alu_src    = 1'b1;  // base plus offset
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = WB_MEM;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_JAL: begin
                ctrl.regdst     = REGDST_RA;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = ALU_LINK;
                ctrl.mem_to_reg = WB_LINK;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) ctrl = '0;  // unknown encodings leave as a bubble
    end

    // a load and a store in one decode would corrupt the memory stage
    always_comb begin
        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("decoder drove mem_read and mem_write together");
    end

endmodule

/* design/register_file.sv */
module register_file
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    // register zero has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != REG_ZERO)) begin
            regs[wr_addr] <= wr_data;  // writes to $zero are dropped
        end
    end

    // no write bypass, same-cycle read returns the old value
    assign rs_data = (rs_addr == REG_ZERO) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == REG_ZERO) ? '0 : regs[rt_addr];

    // a write to a real register is visible on the following read
    a_write_visible: assert property (
        @(posedge clk) disable iff (reset)
            (we && (wr_addr != REG_ZERO)) |=>
                (rs_addr != $past(wr_addr)) || (rs_data == $past(wr_data))
    ) else $error("register file lost a write");

endmodule

/* design/id_ex.sv */
module id_ex
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  ex_bundle_t d,
    output ex_bundle_t q
);

    // stall turns the slot into a bubble, the stage before holds its instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= EX_BUBBLE;
        end else if (stall) begin
            q <= EX_BUBBLE;
        end else begin
            q <= d;
        end
    end

    // a stalled slot must never write a register or touch memory downstream
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (reset)
            stall |=> (q.ctrl == '0) && !q.illegal
    ) else $error("id_ex did not bubble after stall");

endmodule

/* design/alu_execute.sv */
module alu_execute
    import isa_pkg::*, pipe_pkg::*;
(
    input  ex_bundle_t bundle,
    output ex_out_t    ex_out
);

    word_t     op_a;
    word_t     op_b;
    word_t     result;
    reg_addr_t dest;

    assign op_a = bundle.rs_data;
    assign op_b = bundle.ctrl.alu_src ? bundle.imm : bundle.rt_data;

    always_comb begin
        case (bundle.ctrl.regdst)
            REGDST_RD: dest = bundle.rd;
            REGDST_RA: dest = REG_RA;  // jal
            default:   dest = bundle.rt;
        endcase
    end

    always_comb begin
        case (bundle.ctrl.alu_op)
            ALU_ADD:  result = op_a + op_b;  // wraps
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = word_t'(op_a < op_b);
            // shifts take rt and the shamt field, never rs
            ALU_SLL:  result = bundle.rt_data << bundle.shamt;
            ALU_SRL:  result = bundle.rt_data >> bundle.shamt;
            ALU_SRA:  result = word_t'($signed(bundle.rt_data) >>> bundle.shamt);
            ALU_LUI:  result = bundle.imm << 16;
            ALU_LINK: result = bundle.pc + LINK_OFFSET;
            default:  result = '0;
        endcase
    end

    always_comb begin
        ex_out            = '0;
        ex_out.result     = result;
        ex_out.dest       = dest;
        ex_out.store_data = bundle.rt_data;  // sw data
        ex_out.reg_write  = bundle.ctrl.reg_write;
        ex_out.mem_read   = bundle.ctrl.mem_read;
        ex_out.mem_write  = bundle.ctrl.mem_write;
        ex_out.mem_to_reg = bundle.ctrl.mem_to_reg;
    end

endmodule

/* design/mips_id_ex_stage.sv */
module mips_id_ex_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  word_t     instr,
    input  word_t     pc,
    input  logic      wb_we,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output ex_out_t   ex_out,
    output logic      illegal
);

    instr_fields_t fields;
    ctrl_t         dec_ctrl;
    word_t         dec_imm;
    logic          dec_illegal;
    word_t         rs_data;
    word_t         rt_data;
    ex_bundle_t    id_bundle;
    ex_bundle_t    ex_bundle;

    assign fields = instr_fields_t'(instr);

    control_decoder i_control_decoder (
        .instr   (instr),
        .ctrl    (dec_ctrl),
        .imm     (dec_imm),
        .illegal (dec_illegal)
    );

    register_file i_register_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (fields.rs),
        .rt_addr (fields.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (wb_we),
        .wr_addr (wb_addr),
        .wr_data (wb_data)
    );

    assign id_bundle = '{
        ctrl:    dec_ctrl,
        illegal: dec_illegal,
        pc:      pc,
        rs_data: rs_data,
        rt_data: rt_data,
        imm:     dec_imm,
        rs:      fields.rs,
        rt:      fields.rt,
        rd:      fields.rd,
        shamt:   fields.shamt
    };

    id_ex i_id_ex (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .d     (id_bundle),
        .q     (ex_bundle)
    );

    alu_execute i_alu_execute (
        .bundle (ex_bundle),
        .ex_out (ex_out)
    );

    assign illegal = ex_bundle.illegal;  // flagged in the execute cycle

endmodule

/* verif/tb_mips_id_ex_stage.sv */
module tb_mips_id_ex_stage
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIELDS   = 12;  // words per vector line
    localparam int MAX_VECS = 64;

    logic      clk;
    logic      reset;
    logic      stall;
    word_t     instr;
    word_t     pc;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    ex_out_t   ex_out;
    logic      illegal;

    word_t vec_mem [FIELDS*MAX_VECS];
    int    num_vecs;
    int    vec_pass;
    int    vec_fail;
    int    vec_errors;  // mismatches in the vector being checked
    logic  vectors_loaded;

    mips_id_ex_stage i_mips_id_ex_stage (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .instr   (instr),
        .pc      (pc),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .ex_out  (ex_out),
        .illegal (illegal)
    );

    always #10 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
            vec_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            vec_errors++;
        end
    endtask

    // only the memory and writeback bits, result and dest have their own checks
    task automatic check_ctrl(input ex_out_t exp, input ex_out_t act);
        logic [4:0] exp_bits;
        logic [4:0] act_bits;
        exp_bits = {exp.reg_write, exp.mem_read, exp.mem_write, exp.mem_to_reg};
        act_bits = {act.reg_write, act.mem_read, act.mem_write, act.mem_to_reg};
        if (exp_bits !== act_bits) begin
            $display("** Error at %0t: ex_out control expected %b got %b",
                     $time, exp_bits, act_bits);
            vec_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
            vec_errors++;
        end
    endtask

    task automatic drive_vector(input int k);
        int base;
        base    = k * FIELDS;
        reset   = vec_mem[base][0];
        stall   = vec_mem[base+1][0];
        instr   = vec_mem[base+2];
        pc      = vec_mem[base+3];
        wb_we   = vec_mem[base+4][0];
        wb_addr = reg_addr_t'(vec_mem[base+5]);
        wb_data = vec_mem[base+6];
    endtask

    task automatic check_vector(input int k);
        int         base;
        ex_out_t    exp;
        logic [4:0] nib;
        base           = k * FIELDS;
        vec_errors     = 0;
        nib            = vec_mem[base+10][4:0];  // reg_write mem_read mem_write mem_to_reg
        exp            = '0;
        exp.result     = vec_mem[base+7];
        exp.dest       = reg_addr_t'(vec_mem[base+8]);
        exp.store_data = vec_mem[base+9];
        exp.reg_write  = nib[4];
        exp.mem_read   = nib[3];
        exp.mem_write  = nib[2];
        exp.mem_to_reg = wb_sel_e'(nib[1:0]);
        check_word("ex_out.result", exp.result, ex_out.result);
        check_reg("ex_out.dest", exp.dest, ex_out.dest);
        if (exp.mem_write) begin
            check_word("ex_out.store_data", exp.store_data, ex_out.store_data);
        end
        check_ctrl(exp, ex_out);
        check_flag("illegal", vec_mem[base+11][0], illegal);
        if (vec_errors == 0) begin
            vec_pass++;
            $display("vector %0d passed", k);
        end else begin
            vec_fail++;
            $display("vector %0d failed with %0d mismatches", k, vec_errors);
        end
    endtask

    // reset clears id_ex at once, without waiting for a clock edge
    task automatic check_reset_clear(input int k);
        ex_out_t cleared;
        cleared    = '0;
        vec_errors = 0;
        check_word("ex_out.result", cleared.result, ex_out.result);
        check_reg("ex_out.dest", cleared.dest, ex_out.dest);
        check_ctrl(cleared, ex_out);
        check_flag("illegal", 1'b0, illegal);
        if (vec_errors == 0) begin
            vec_pass++;
            $display("reset at vector %0d cleared the outputs", k);
        end else begin
            vec_fail++;
            $display("reset at vector %0d failed with %0d mismatches", k, vec_errors);
        end
    endtask

    // watchdog, one clock per vector plus slack for reset
    initial begin
        wait (vectors_loaded);
        #((num_vecs + 20) * 20);
        $display("watchdog expired, the vectors did not finish");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        stall          = 1'b1;  // keeps id_ex empty while reset releases
        instr          = '0;
        pc             = '0;
        wb_we          = 1'b0;
        wb_addr        = '0;
        wb_data        = '0;
        num_vecs       = 0;
        vec_pass       = 0;
        vec_fail       = 0;
        vec_errors     = 0;
        vectors_loaded = 1'b0;

        // marker words past the end of the file, never a valid reset column
        for (int i = 0; i < FIELDS*MAX_VECS; i++) begin
            vec_mem[i] = {16'hdead, 16'(i)};
        end
        $readmemh("verif/mips_id_ex_vectors.txt", vec_mem);
        while (num_vecs < MAX_VECS && vec_mem[num_vecs*FIELDS] <= 32'd1) begin
            num_vecs++;
        end
        vectors_loaded = 1'b1;

        repeat (8) @(posedge clk);

        // line k is driven at one falling edge and checked at the next
        for (int k = 0; k <= num_vecs; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_vector(k - 1);
            end
            if (k < num_vecs) begin
                drive_vector(k);
                if (reset) begin
                    #1;
                    check_reset_clear(k);
                end
            end
        end

        $display("%0d tests passed, %0d tests failed", vec_pass, vec_fail);
        if (vec_fail == 0 && num_vecs > 0) begin
            $display("Simulation PASSED");
        end else begin
            if (num_vecs == 0) begin
                $display("no vectors were loaded");
            end
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verif/mips_id_ex_vectors.txt */
// rst stall instr pc we waddr wdata, then expected result dest store_data ctrl illegal
// ctrl = {reg_write, mem_read, mem_write, mem_to_reg[1:0]}, one cycle per line
0 1 00000000 00000000 1 01 00000005 00000000 00 00000000 00 0  // load r1..r4
0 1 00000000 00000000 1 02 00000003 00000000 00 00000000 00 0
0 1 00000000 00000000 1 03 fffffff0 00000000 00 00000000 00 0
0 1 00000000 00000000 1 04 80000000 00000000 00 00000000 00 0
0 1 00000000 00000000 1 00 12345678 00000000 00 00000000 00 0  // r0 stays zero
0 0 00222820 00000000 0 00 00000000 00000008 05 00000000 10 0  // add
0 0 00413022 00000000 0 00 00000000 fffffffe 06 00000000 10 0  // sub
0 0 00223824 00000000 0 00 00000000 00000001 07 00000000 10 0  // and
0 0 00234025 00000000 0 00 00000000 fffffff5 08 00000000 10 0  // or
0 0 00224826 00000000 0 00 00000000 00000006 09 00000000 10 0  // xor
0 0 00225027 00000000 0 00 00000000 fffffff8 0a 00000000 10 0  // nor
0 0 0061582a 00000000 0 00 00000000 00000001 0b 00000000 10 0  // slt
0 0 0061602b 00000000 0 00 00000000 00000000 0c 00000000 10 0  // sltu
0 0 00016820 00000000 0 00 00000000 00000005 0d 00000000 10 0  // add r0 + r1
0 0 00027100 00000000 0 00 00000000 00000030 0e 00000000 10 0  // sll
0 0 00047902 00000000 0 00 00000000 08000000 0f 00000000 10 0  // srl
0 0 00048103 00000000 0 00 00000000 f8000000 10 00000000 10 0  // sra
0 0 3071ff0f 00000000 0 00 00000000 0000ff00 11 00000000 10 0  // andi
0 0 34328000 00000000 0 00 00000000 00008005 12 00000000 10 0  // ori
0 0 3873ffff 00000000 0 00 00000000 ffff000f 13 00000000 10 0  // xori
0 0 2034fff8 00000000 0 00 00000000 fffffffd 14 00000000 10 0  // addi
0 0 2835ffff 00000000 0 00 00000000 00000000 15 00000000 10 0  // slti
0 0 3c16abcd 00000000 0 00 00000000 abcd0000 16 00000000 10 0  // lui
0 0 8c370010 00000000 0 00 00000000 00000015 17 00000000 19 0  // lw
0 0 ac22fffc 00000000 0 00 00000000 00000001 02 00000003 04 0  // sw
0 0 0c000040 00400020 0 00 00000000 00400028 1f 00000000 12 0  // jal
0 1 00222820 00000000 0 00 00000000 00000000 00 00000000 00 0  // stalled add
0 0 00224826 00000000 0 00 00000000 00000006 09 00000000 10 0
0 0 fc000000 00000000 0 00 00000000 00000000 00 00000000 00 1  // bad opcode
0 0 0022283f 00000000 0 00 00000000 00000008 02 00000000 00 1  // bad funct
1 1 00000000 00000000 0 00 00000000 00000000 00 00000000 00 0  // mid-run reset
0 0 00222820 00000000 0 00 00000000 00000000 05 00000000 10 0
0 0 00234025 00000000 0 00 00000000 00000000 08 00000000 10 0

/* mips_id_ex_stage.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/control_decoder.sv
design/register_file.sv
design/id_ex.sv
design/alu_execute.sv
design/mips_id_ex_stage.sv
verif/tb_mips_id_ex_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mips_id_ex_stage
FILELIST  = mips_id_ex_stage.f
BUILD     = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)
